// ==== hdl/ncpu_pkg.sv ====
/*
 * Shared definitions of the three-stage integer core:
 * widths, opcodes, unit selects and the views of an instruction word
 */
package ncpu_pkg;

   localparam int NCPU_DW         = 32;   // Data width
   localparam int NCPU_AW         = 32;   // Address width
   localparam int NCPU_REG_AW     = 5;    // Register address width
   localparam int NCPU_INSN_BYTES = 4;    // Step of the program counter

   // Kept opcodes, anything else runs as a no-operation
   typedef enum logic [5:0] {
      OP_LDW   = 6'd1,
      OP_STW   = 6'd2,
      OP_AND   = 6'd3,
      OP_AND_I = 6'd4,
      OP_OR    = 6'd5,
      OP_OR_I  = 6'd6,
      OP_XOR   = 6'd7,
      OP_XOR_I = 6'd8,
      OP_LSL   = 6'd9,
      OP_LSL_I = 6'd10,
      OP_LSR   = 6'd11,
      OP_LSR_I = 6'd12,
      OP_ASR   = 6'd13,
      OP_ASR_I = 6'd14,
      OP_ADD   = 6'd15,
      OP_ADD_I = 6'd16,
      OP_SUB   = 6'd17,
      OP_JMP_I = 6'd19
   } opcode_e;

   typedef enum logic [2:0] {LU_NONE, LU_AND, LU_OR, LU_XOR, LU_LSL, LU_LSR, LU_ASR} lu_op_e;

   typedef enum logic [1:0] {AU_NONE, AU_ADD, AU_SUB} au_op_e;

   ////////////////////////////////////////
   // Instruction word views

   typedef struct packed {
      logic [10:0]            attr;
      logic [NCPU_REG_AW-1:0] rs2;
      logic [NCPU_REG_AW-1:0] rs1;
      logic [NCPU_REG_AW-1:0] rd;
      logic [5:0]             opcode;
   } insn_reg_t;

   typedef struct packed {
      logic [15:0]            imm16;
      logic [NCPU_REG_AW-1:0] rs1;
      logic [NCPU_REG_AW-1:0] rd;
      logic [5:0]             opcode;
   } insn_imm_t;

   typedef struct packed {
      logic [20:0]            rel21;  // Offset in instructions
      logic [NCPU_REG_AW-1:0] pad;
      logic [5:0]             opcode;
   } insn_rel_t;

   typedef union packed {
      insn_reg_t r;
      insn_imm_t i;
      insn_rel_t j;
   } insn_u;

endpackage

// ==== hdl/ncpu_ifs.sv ====
/*
 * Stage interfaces: decode to execute, and the register file ports
 */
`timescale 1ns/1ps

interface exec_if import ncpu_pkg::*; ();
   logic                   valid;
   lu_op_e                 lu_op;
   au_op_e                 au_op;
   logic [NCPU_DW-1:0]     operand_1;
   logic [NCPU_DW-1:0]     operand_2;
   logic [NCPU_DW-1:0]     store_data;
   logic                   is_load;
   logic                   is_store;
   logic                   wb_en;
   logic [NCPU_REG_AW-1:0] wb_addr;
   logic                   hold;      // Execute waits on the data bus

   modport dec (output valid, lu_op, au_op, operand_1, operand_2, store_data,
                output is_load, is_store, wb_en, wb_addr, input hold);
   modport exe (input valid, lu_op, au_op, operand_1, operand_2, store_data,
                input is_load, is_store, wb_en, wb_addr, output hold);
endinterface

interface regfile_if import ncpu_pkg::*; ();
   logic [NCPU_REG_AW-1:0] rd_addr1;
   logic [NCPU_REG_AW-1:0] rd_addr2;
   logic                   rd_en;
   logic [NCPU_DW-1:0]     rd_data1;  // Valid the cycle after an enabled read
   logic [NCPU_DW-1:0]     rd_data2;
   logic                   wr_en;
   logic [NCPU_REG_AW-1:0] wr_addr;
   logic [NCPU_DW-1:0]     wr_data;

   modport rd_port (output rd_addr1, rd_addr2, rd_en, input rd_data1, rd_data2);
   modport wr_port (output wr_en, wr_addr, wr_data);
   modport file (input rd_addr1, rd_addr2, rd_en, wr_en, wr_addr, wr_data,
                 output rd_data1, rd_data2);
endinterface

// ==== hdl/ncpu_fetch.sv ====
/*
 * Fetch stage: program counter, pending jump target and the decode instruction register
 */
`timescale 1ns/1ps

module ncpu_fetch import ncpu_pkg::*; #(
   parameter logic [NCPU_AW-1:0] RESET_VECTOR = '0
) (
   input  logic               clk_i,
   input  logic               reset_i,
   input  insn_u              insn_i,
   input  logic               insn_ready_i,
   input  logic               hold_i,
   input  logic               jump_i,
   input  logic [20:0]        jump_offset_i,
   output logic [NCPU_AW-1:0] iaddr_o,
   output insn_u              insn_o,
   output logic               insn_valid_o
);
   logic [NCPU_AW-1:0] pc;
   logic [NCPU_AW-1:0] jump_target;
   logic [NCPU_AW-1:0] pend_target;
   logic               pend;
   logic               capture;

   assign iaddr_o = pc;
   assign capture = insn_ready_i & ~hold_i;

   // pc points at the delay slot when the strobe arrives
   assign jump_target = pc + {{(NCPU_AW-23){jump_offset_i[20]}}, jump_offset_i, 2'b00};

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pc <= RESET_VECTOR;
         pend <= 1'b0;
         insn_valid_o <= 1'b0;
      end else begin
         if (!hold_i) begin
            insn_valid_o <= insn_ready_i;   // Bubble while the bus is not ready
         end
         if (capture) begin
            // Delay slot captured now, redirect after it
            if (jump_i) begin
               pc <= jump_target;
            end else if (pend) begin
               pc <= pend_target;
            end else begin
               pc <= pc + NCPU_AW'(NCPU_INSN_BYTES);
            end
            pend <= 1'b0;
         end else if (jump_i) begin
            pend <= 1'b1;   // Slot not fetched yet
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (capture) begin
         insn_o <= insn_i;
      end
      if (jump_i) begin
         pend_target <= jump_target;
      end
   end

endmodule

// ==== hdl/ncpu_decode.sv ====
/*
 * Decode stage: opcode decode, immediate extension, register read
 * and the registers that feed execute
 */
`timescale 1ns/1ps

module ncpu_decode import ncpu_pkg::*; (
   input  logic        clk_i,
   input  logic        reset_i,
   input  insn_u       insn_i,
   input  logic        insn_valid_i,
   output logic        jump_o,
   output logic [20:0] jump_offset_o,
   regfile_if.rd_port  rf,
   exec_if.dec         ex
);
   opcode_e            opc;
   lu_op_e             lu_op;
   au_op_e             au_op;
   logic               is_load;
   logic               is_store;
   logic               is_jmp;
   logic               imm_sel;
   logic               imm_sext;
   logic               wb_en;
   logic               rs1_used;
   logic [NCPU_DW-1:0] imm_ext;
   logic [NCPU_DW-1:0] imm_q;
   logic               imm_sel_q;
   logic               rs1_used_q;

   ////////////////////////////////////////
   // Field decode

   assign opc = opcode_e'(insn_i.r.opcode);

   always_comb begin
      case (opc)
         OP_AND, OP_AND_I: lu_op = LU_AND;
         OP_OR, OP_OR_I:   lu_op = LU_OR;
         OP_XOR, OP_XOR_I: lu_op = LU_XOR;
         OP_LSL, OP_LSL_I: lu_op = LU_LSL;
         OP_LSR, OP_LSR_I: lu_op = LU_LSR;
         OP_ASR, OP_ASR_I: lu_op = LU_ASR;
         default:          lu_op = LU_NONE;
      endcase
      case (opc)
         OP_ADD, OP_ADD_I: au_op = AU_ADD;
         OP_SUB:           au_op = AU_SUB;
         default:          au_op = AU_NONE;   // Also the address add of ldw/stw
      endcase
   end

   assign is_load  = (opc == OP_LDW);
   assign is_store = (opc == OP_STW);
   assign is_jmp   = (opc == OP_JMP_I);
   assign imm_sel  = opc inside {OP_AND_I, OP_OR_I, OP_XOR_I, OP_LSL_I, OP_LSR_I,
                                 OP_ASR_I, OP_ADD_I, OP_LDW, OP_STW};
   assign imm_sext = opc inside {OP_AND_I, OP_XOR_I, OP_LDW, OP_STW};
   assign wb_en    = (lu_op != LU_NONE) | (au_op != AU_NONE) | is_load;
   assign rs1_used = wb_en | is_store;

   assign imm_ext = imm_sext ? {{(NCPU_DW-16){insn_i.i.imm16[15]}}, insn_i.i.imm16}
                             : {{(NCPU_DW-16){1'b0}}, insn_i.i.imm16};

   // Stores read rd on port 2 as the data to write
   assign rf.rd_en    = ~ex.hold;
   assign rf.rd_addr1 = insn_i.r.rs1;
   assign rf.rd_addr2 = is_store ? insn_i.r.rd : insn_i.r.rs2;

   // One strobe per jump, as it leaves decode
   assign jump_o        = insn_valid_i & is_jmp & ~ex.hold;
   assign jump_offset_o = insn_i.j.rel21;

   ////////////////////////////////////////
   // Decode to execute registers

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ex.valid <= 1'b0;
         ex.is_load <= 1'b0;
         ex.is_store <= 1'b0;
         ex.wb_en <= 1'b0;
      end else if (!ex.hold) begin
         ex.valid <= insn_valid_i;
         ex.is_load <= is_load;
         ex.is_store <= is_store;
         ex.wb_en <= wb_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!ex.hold) begin
         ex.lu_op <= lu_op;
         ex.au_op <= au_op;
         ex.wb_addr <= insn_i.r.rd;
         imm_q <= imm_ext;
         imm_sel_q <= imm_sel;
         rs1_used_q <= rs1_used;
      end
   end

   // Register values arrive a cycle late, so the mux sits after the read
   assign ex.operand_1  = rs1_used_q ? rf.rd_data1 : imm_q;
   assign ex.operand_2  = imm_sel_q ? imm_q : rf.rd_data2;
   assign ex.store_data = rf.rd_data2;

endmodule

// ==== hdl/ncpu_regfile.sv ====
/*
 * 32-entry register file, two registered read ports with write bypass
 */
`timescale 1ns/1ps

module ncpu_regfile import ncpu_pkg::*; (
   input  logic    clk_i,
   input  logic    reset_i,
   regfile_if.file rf
);
   logic [NCPU_DW-1:0] regs [2**NCPU_REG_AW];

   // Same-cycle write wins over the stored value
   function automatic logic [NCPU_DW-1:0] read_port(input logic [NCPU_REG_AW-1:0] addr);
      return (rf.wr_en && rf.wr_addr == addr) ? rf.wr_data : regs[addr];
   endfunction

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < 2**NCPU_REG_AW; i++) begin
            regs[i] <= '0;
         end
      end else if (rf.wr_en) begin
         regs[rf.wr_addr] <= rf.wr_data;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rf.rd_en) begin
         rf.rd_data1 <= read_port(rf.rd_addr1);
         rf.rd_data2 <= read_port(rf.rd_addr2);
      end
   end

endmodule

// ==== hdl/ncpu_execute.sv ====
/*
 * Execute stage: logic unit, shifter, adder, data bus control,
 * writeback and the pipeline hold
 */
`timescale 1ns/1ps

module ncpu_execute import ncpu_pkg::*; (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic [NCPU_DW-1:0] d_i,
   input  logic               dbus_rd_ready_i,
   input  logic               dbus_we_done_i,
   output logic [NCPU_DW-1:0] d_o,
   output logic [NCPU_AW-1:0] addr_o,
   output logic               dbus_rd_o,
   output logic               dbus_we_o,
   exec_if.exe                ex,
   regfile_if.wr_port         wb
);
   logic [NCPU_DW-1:0]   shift_lsw;
   logic [NCPU_DW-1:0]   shift_msw;
   logic [2*NCPU_DW-1:0] shift_wide;
   logic [NCPU_DW-1:0]   lu_shift;
   logic [NCPU_DW-1:0]   lu_result;
   logic                 adder_sub;
   logic [NCPU_DW-1:0]   adder_op2;
   logic [NCPU_DW-1:0]   sum;
   logic [NCPU_DW-1:0]   wb_data;
   logic                 load_wait;
   logic                 store_wait;

   function automatic logic [NCPU_DW-1:0] reverse_bits(input logic [NCPU_DW-1:0] a);
      logic [NCPU_DW-1:0] r;
      for (int i = 0; i < NCPU_DW; i++) begin
         r[NCPU_DW-1-i] = a[i];
      end
      return r;
   endfunction

   ////////////////////////////////////////
   // Logic unit and shifter

   // lsl runs through the right shifter on reversed bits
   assign shift_lsw  = (ex.lu_op == LU_LSL) ? reverse_bits(ex.operand_1) : ex.operand_1;
   assign shift_msw  = (ex.lu_op == LU_ASR) ? {NCPU_DW{ex.operand_1[NCPU_DW-1]}} : '0;
   assign shift_wide = {shift_msw, shift_lsw} >> ex.operand_2[4:0];
   assign lu_shift   = (ex.lu_op == LU_LSL) ? reverse_bits(shift_wide[NCPU_DW-1:0])
                                            : shift_wide[NCPU_DW-1:0];

   always_comb begin
      case (ex.lu_op)
         LU_AND:                 lu_result = ex.operand_1 & ex.operand_2;
         LU_OR:                  lu_result = ex.operand_1 | ex.operand_2;
         LU_XOR:                 lu_result = ex.operand_1 ^ ex.operand_2;
         LU_LSL, LU_LSR, LU_ASR: lu_result = lu_shift;
         default:                lu_result = '0;
      endcase
   end

   // Adder, shared with the load/store address
   assign adder_sub = (ex.au_op == AU_SUB);
   assign adder_op2 = adder_sub ? ~ex.operand_2 : ex.operand_2;
   assign sum       = ex.operand_1 + adder_op2 + NCPU_DW'(adder_sub);

   ////////////////////////////////////////
   // Data bus and hold

   assign addr_o    = sum[NCPU_AW-1:0];
   assign d_o       = ex.store_data;
   assign dbus_rd_o = ex.valid & ex.is_load;
   assign dbus_we_o = ex.valid & ex.is_store;

   assign load_wait  = ex.is_load & ~dbus_rd_ready_i;
   assign store_wait = ex.is_store & ~dbus_we_done_i;
   assign ex.hold    = ex.valid & (load_wait | store_wait);

   // Writeback
   always_comb begin
      if (ex.is_load) begin
         wb_data = d_i;
      end else if (ex.au_op != AU_NONE) begin
         wb_data = sum;
      end else begin
         wb_data = lu_result;
      end
   end

   assign wb.wr_en   = ex.valid & ex.wb_en & ~ex.hold;
   assign wb.wr_addr = ex.wb_addr;
   assign wb.wr_data = wb_data;

endmodule

// ==== hdl/ncpu_core.sv ====
/*
 * Three-stage integer core top: fetch, decode and execute around the register file
 */
`timescale 1ns/1ps

module ncpu_core import ncpu_pkg::*; #(
   parameter logic [NCPU_AW-1:0] RESET_VECTOR = '0
) (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic [NCPU_DW-1:0] insn_i,
   input  logic               insn_ready_i,
   input  logic [NCPU_DW-1:0] d_i,
   input  logic               dbus_rd_ready_i,
   input  logic               dbus_we_done_i,
   output logic [NCPU_AW-1:0] iaddr_o,
   output logic               ibus_rd_o,
   output logic [NCPU_AW-1:0] addr_o,
   output logic [NCPU_DW-1:0] d_o,
   output logic               dbus_rd_o,
   output logic               dbus_we_o
);
   exec_if    exec_bus ();
   regfile_if rf_bus ();

   insn_u       dec_insn;
   logic        dec_insn_valid;
   logic        jump;
   logic [20:0] jump_offset;

   assign ibus_rd_o = 1'b1;   // Fetch reads every cycle

   ncpu_fetch #(
      .RESET_VECTOR (RESET_VECTOR)
   ) fetch_u (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .insn_i        (insn_i),
      .insn_ready_i  (insn_ready_i),
      .hold_i        (exec_bus.hold),
      .jump_i        (jump),
      .jump_offset_i (jump_offset),
      .iaddr_o       (iaddr_o),
      .insn_o        (dec_insn),
      .insn_valid_o  (dec_insn_valid)
   );

   ncpu_decode decode_u (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .insn_i        (dec_insn),
      .insn_valid_i  (dec_insn_valid),
      .jump_o        (jump),
      .jump_offset_o (jump_offset),
      .rf            (rf_bus),
      .ex            (exec_bus)
   );

   ncpu_regfile regfile_u (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .rf      (rf_bus)
   );

   ncpu_execute execute_u (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .d_i             (d_i),
      .dbus_rd_ready_i (dbus_rd_ready_i),
      .dbus_we_done_i  (dbus_we_done_i),
      .d_o             (d_o),
      .addr_o          (addr_o),
      .dbus_rd_o       (dbus_rd_o),
      .dbus_we_o       (dbus_we_o),
      .ex              (exec_bus),
      .wb              (rf_bus)
   );

endmodule

// ==== testbench/core_checker.sv ====
/*
 * Core checker: instruction-level model of the program, compared with the
 * fetch address and strobe, load addresses and stores that the core puts on its ports
 */
`timescale 1ns/1ps

module core_checker import ncpu_pkg::*; #(
   parameter int                 PROG_LEN     = 200,
   parameter logic [NCPU_AW-1:0] RESET_VECTOR = '0
) (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic [31:0]        prog_i [PROG_LEN],
   input  logic [NCPU_AW-1:0] iaddr_i,
   input  logic               ibus_rd_i,
   input  logic               insn_ready_i,
   input  logic [NCPU_AW-1:0] addr_i,
   input  logic [NCPU_DW-1:0] wdata_i,
   input  logic               dbus_rd_i,
   input  logic               rd_ready_i,
   input  logic               dbus_we_i,
   input  logic               we_done_i,
   output logic               done_o,
   output int                 value_errs_o,
   output int                 other_errs_o
);
   logic [31:0] fetch_q [$];    // Addresses in execution order
   logic [31:0] load_q [$];
   logic [31:0] st_addr_q [$];
   logic [31:0] st_data_q [$];
   logic        first_cycle;
   int          value_errs = 0;
   int          other_errs = 0;

   assign value_errs_o = value_errs;
   assign other_errs_o = other_errs;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         value_errs++;
         $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_error(input string what);
      other_errs++;
      $display("Error at %0t: %s", $time, what);
   endtask

   ////////////////////////////////////////
   // Instruction-level model

   task automatic run_model();
      logic [31:0] r [32];
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] op2;
      logic [31:0] sx;
      logic [31:0] res;
      logic        wr;
      int          idx;
      int          next_idx;
      int          pend;
      for (int k = 0; k < 32; k++) begin
         r[k] = '0;
      end
      idx = 0;
      pend = -1;
      while (idx < PROG_LEN) begin
         w = prog_i[idx];
         a = r[w[15:11]];
         sx = {{16{w[31]}}, w[31:16]};
         op2 = r[w[20:16]];
         if (w[5:0] inside {OP_AND_I, OP_XOR_I}) begin
            op2 = sx;
         end else if (w[5:0] inside {OP_OR_I, OP_LSL_I, OP_LSR_I, OP_ASR_I, OP_ADD_I}) begin
            op2 = {16'h0, w[31:16]};   // Zero extended
         end
         fetch_q.push_back(RESET_VECTOR + 32'(idx * NCPU_INSN_BYTES));
         next_idx = (pend >= 0) ? pend : idx + 1;   // Slot done, go to target
         pend = -1;
         wr = 1'b1;
         case (w[5:0])
            OP_AND, OP_AND_I: res = a & op2;
            OP_OR, OP_OR_I:   res = a | op2;
            OP_XOR, OP_XOR_I: res = a ^ op2;
            OP_LSL, OP_LSL_I: res = a << op2[4:0];
            OP_LSR, OP_LSR_I: res = a >> op2[4:0];
            OP_ASR, OP_ASR_I: res = $signed(a) >>> op2[4:0];
            OP_ADD, OP_ADD_I: res = a + op2;
            OP_SUB:           res = a - op2;
            OP_LDW: begin
               load_q.push_back(a + sx);
               res = ~(a + sx);   // Memory model returns the inverted address
            end
            OP_STW: begin
               st_addr_q.push_back(a + sx);
               st_data_q.push_back(r[w[10:6]]);
               wr = 1'b0;
            end
            OP_JMP_I: begin
               // Counter at the strobe already points past the jump
               pend = idx + 1 + int'($signed(w[31:11]));
               wr = 1'b0;
            end
            default: wr = 1'b0;
         endcase
         if (wr) begin
            r[w[10:6]] = res;
         end
         idx = next_idx;
      end
   endtask

   initial begin
      @(negedge reset_i);
      run_model();
   end

   ////////////////////////////////////////
   // Port monitor

   always @(posedge clk_i) begin
      if (reset_i) begin
         first_cycle = 1'b1;
         done_o = 1'b0;
         if (dbus_rd_i || dbus_we_i) begin
            report_error("data bus strobe high during reset");
         end
      end else begin
         if (first_cycle) begin
            check_value("iaddr_o", iaddr_i, RESET_VECTOR);
         end
         first_cycle = 1'b0;
         check_value("ibus_rd_o", {31'b0, ibus_rd_i}, 32'd1);   // Fetch reads every cycle
         if (dbus_rd_i && dbus_we_i) begin
            report_error("load and store strobes high together");
         end
         // Capture unless the bus keeps execute waiting
         if (insn_ready_i && !(dbus_rd_i && !rd_ready_i) && !(dbus_we_i && !we_done_i)
             && fetch_q.size() > 0) begin
            check_value("iaddr_o", iaddr_i, fetch_q.pop_front());
         end
         if (dbus_rd_i && rd_ready_i) begin
            if (load_q.size() == 0) begin
               report_error("load that the program does not execute");
            end else begin
               check_value("addr_o", addr_i, load_q.pop_front());
            end
         end
         if (dbus_we_i && we_done_i) begin
            if (st_addr_q.size() == 0) begin
               report_error("store that the program does not execute");
            end else begin
               check_value("addr_o", addr_i, st_addr_q.pop_front());
               check_value("d_o", wdata_i, st_data_q.pop_front());
            end
         end
         done_o = (fetch_q.size() == 0) && (load_q.size() == 0) && (st_addr_q.size() == 0);
      end
   end

endmodule

// ==== testbench/tb_core.sv ====
/*
 * Testbench for the three-stage core: random program, instruction and
 * data bus models, reset and the watchdog
 */
`timescale 1ns/1ps

module tb_core import ncpu_pkg::*; ();
   localparam int                 CLK_PERIOD   = 20;
   localparam int                 PROG_LEN     = 200;
   localparam logic [NCPU_AW-1:0] RESET_VECTOR = 32'h0000_0100;
   localparam logic [5:0]         KEPT_OPS [18] = '{
      OP_LDW, OP_STW, OP_AND, OP_AND_I, OP_OR, OP_OR_I, OP_XOR, OP_XOR_I, OP_LSL,
      OP_LSL_I, OP_LSR, OP_LSR_I, OP_ASR, OP_ASR_I, OP_ADD, OP_ADD_I, OP_SUB, OP_JMP_I};

   logic               clk = 1'b0;
   logic               reset;
   logic [NCPU_DW-1:0] insn;
   logic               insn_ready;
   logic [NCPU_DW-1:0] d_in;
   logic               rd_ready;
   logic               we_done;
   logic [NCPU_AW-1:0] iaddr;
   logic               ibus_rd;
   logic [NCPU_AW-1:0] addr;
   logic [NCPU_DW-1:0] d_out;
   logic               dbus_rd;
   logic               dbus_we;
   logic [31:0]        prog [PROG_LEN];
   logic [31:0]        rng = 32'h1c1c5440;
   logic [1:0]         ld_wait;   // Cycles left before the load strobe
   logic [1:0]         st_wait;
   logic               done;
   int                 value_errs;
   int                 other_errs;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] fetch_word(input logic [NCPU_AW-1:0] a);
      logic [NCPU_AW-1:0] offset;
      offset = a - RESET_VECTOR;
      if (a >= RESET_VECTOR && offset < NCPU_AW'(PROG_LEN * NCPU_INSN_BYTES)) begin
         return prog[offset[NCPU_AW-1:2]];
      end
      return '0;   // Opcode 0 is a no-operation
   endfunction

   // Random body, then one store per register
   task automatic build_program();
      logic [31:0] w;
      logic [5:0]  op;
      logic        prev_jmp;
      prev_jmp = 1'b0;
      for (int i = 0; i < PROG_LEN - 32; i++) begin
         rng = xorshift32(rng);
         w = rng;
         rng = xorshift32(rng);
         op = (i < 18) ? KEPT_OPS[i] : KEPT_OPS[int'(rng % 32'd18)];
         // No jump in a delay slot, and every target stays inside the program
         if (op == OP_JMP_I && (prev_jmp || i > PROG_LEN - 37)) begin
            op = OP_ADD;
         end
         if (op == OP_JMP_I) begin
            w[31:11] = 21'(rng[9:8]) + 21'd1;
         end
         w[5:0] = op;
         prog[i] = w;
         prev_jmp = (op == OP_JMP_I);
      end
      for (int r = 0; r < 32; r++) begin
         prog[PROG_LEN - 32 + r] = {16'(r * 4), 5'd0, 5'(r), OP_STW};
      end
   endtask

   ncpu_core #(
      .RESET_VECTOR (RESET_VECTOR)
   ) dut_i (
      .clk_i           (clk),
      .reset_i         (reset),
      .insn_i          (insn),
      .insn_ready_i    (insn_ready),
      .d_i             (d_in),
      .dbus_rd_ready_i (rd_ready),
      .dbus_we_done_i  (we_done),
      .iaddr_o         (iaddr),
      .ibus_rd_o       (ibus_rd),
      .addr_o          (addr),
      .d_o             (d_out),
      .dbus_rd_o       (dbus_rd),
      .dbus_we_o       (dbus_we)
   );

   core_checker #(
      .PROG_LEN     (PROG_LEN),
      .RESET_VECTOR (RESET_VECTOR)
   ) checker_u (
      .clk_i        (clk),
      .reset_i      (reset),
      .prog_i       (prog),
      .iaddr_i      (iaddr),
      .ibus_rd_i    (ibus_rd),
      .insn_ready_i (insn_ready),
      .addr_i       (addr),
      .wdata_i      (d_out),
      .dbus_rd_i    (dbus_rd),
      .rd_ready_i   (rd_ready),
      .dbus_we_i    (dbus_we),
      .we_done_i    (we_done),
      .done_o       (done),
      .value_errs_o (value_errs),
      .other_errs_o (other_errs)
   );

   initial begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////
   // Bus models, driven on the falling edge

   always @(negedge clk) begin
      rng = xorshift32(rng);
      insn_ready = (rng[1:0] != 2'b00);
      insn = fetch_word(iaddr);
      if (rd_ready) begin   // Taken at the last rising edge
         rd_ready = 1'b0;
         ld_wait = rng[3:2];
      end else if (dbus_rd) begin
         if (ld_wait == 2'd0) begin
            rd_ready = 1'b1;
            d_in = ~addr;
         end else begin
            ld_wait--;
         end
      end
      if (we_done) begin
         we_done = 1'b0;
         st_wait = rng[5:4];
      end else if (dbus_we) begin
         if (st_wait == 2'd0) begin
            we_done = 1'b1;
         end else begin
            st_wait--;
         end
      end
   end

   initial begin
      #(CLK_PERIOD * (PROG_LEN * 40 + 16));
      $display("Timeout: program not finished after %0d cycles", PROG_LEN * 40);
      $display("tests failed");
      $finish;
   end

   initial begin
      reset = 1'b1;
      insn = '0;
      insn_ready = 1'b0;
      d_in = '0;
      rd_ready = 1'b0;
      we_done = 1'b0;
      ld_wait = '0;
      st_wait = '0;
      build_program();
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      wait (done);
      repeat (20) @(posedge clk);   // Room for stray stores
      $display("Checks done: %0d value errors, %0d other errors", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== build.f ====
hdl/ncpu_pkg.sv
hdl/ncpu_ifs.sv
hdl/ncpu_fetch.sv
hdl/ncpu_decode.sv
hdl/ncpu_regfile.sv
hdl/ncpu_execute.sv
hdl/ncpu_core.sv
testbench/core_checker.sv
testbench/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
if ! verilator --binary --timing -Wno-fatal --top-module tb_core -f build.f -o tb_core; then
   echo "Verilator build failed"
   exit 1
fi
out=$(./obj_dir/tb_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
if echo "$out" | grep -qx "all tests passed"; then
   exit 0
fi
exit 1
